// ==== source/fc_layer_cfg.svh ====
`ifndef FC_LAYER_CFG_SVH
`define FC_LAYER_CFG_SVH

// layer geometry
`define FC_IN_BYTES     400
`define FC_OUT_CHANNELS 120

// four int8 values per sram word
`define FC_CH_WORDS     (`FC_IN_BYTES / 4)

// one beat reads a word pair from each sram
`define FC_BEATS        (`FC_CH_WORDS / 2)

// strobe to data at the sram outputs
`define FC_RD_LAT       2

// operand queue entries
`define FC_Q_DEPTH      8

`endif

// ==== source/fc_layer_pkg.sv ====
`default_nettype none

package fc_layer_pkg;

    typedef logic [15:0] addr_t;

    typedef logic [31:0] word_t;

    // finished channel sum
    typedef logic signed [31:0] psum_t;

    // lanes 0-3 in word 0, lanes 4-7 in word 1
    typedef struct packed {
        logic  last;
        word_t act1;
        word_t act0;
        word_t wgt1;
        word_t wgt0;
    } operand_beat_t;

    // port 1 always reads addr0 + 1
    typedef struct packed {
        logic  en;
        addr_t addr0;
        addr_t addr1;
    } sram_rd_t;

    typedef struct packed {
        logic       en;
        addr_t      addr;
        logic [3:0] mask;
        word_t      data;
    } result_wr_t;

endpackage

`default_nettype wire

// ==== source/fc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_layer_cfg.svh"

module fc_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  fc_layer_pkg::addr_t         weight_offset,
    input  fc_layer_pkg::addr_t         act_offset,
    input  logic                        almost_full,
    output fc_layer_pkg::sram_rd_t      weight_rd,
    output fc_layer_pkg::sram_rd_t      act_rd,
    input  fc_layer_pkg::word_t         weight_rdata0,
    input  fc_layer_pkg::word_t         weight_rdata1,
    input  fc_layer_pkg::word_t         act_rdata0,
    input  fc_layer_pkg::word_t         act_rdata1,
    output fc_layer_pkg::operand_beat_t beat,
    output logic                        beat_push
);
    import fc_layer_pkg::*;

    localparam int CH_W   = $clog2(`FC_OUT_CHANNELS);
    localparam int BT_W   = $clog2(`FC_BEATS);
    localparam int RD_LAT = `FC_RD_LAT;

    logic              busy;
    logic [CH_W-1:0]   ch;
    logic [BT_W-1:0]   bt;
    logic              issue;
    logic              last_bt;
    addr_t             w_addr;
    addr_t             a_addr;
    logic [RD_LAT-1:0] vld_sr;
    logic [RD_LAT-1:0] last_sr;

    // one read pair per cycle unless the queue is close to full
    assign issue   = busy && !almost_full;
    assign last_bt = (bt == BT_W'(`FC_BEATS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            ch   <= '0;
            bt   <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                ch   <= '0;
                bt   <= '0;
            end
        end else if (issue) begin
            if (last_bt) begin
                bt <= '0;
                if (ch == CH_W'(`FC_OUT_CHANNELS - 1)) begin
                    busy <= 1'b0;
                end else begin
                    ch <= ch + 1'b1;
                end
            end else begin
                bt <= bt + 1'b1;
            end
        end
    end

    // weights are laid out channel by channel
    assign w_addr = weight_offset + addr_t'(ch) * addr_t'(`FC_CH_WORDS)
                  + addr_t'({bt, 1'b0});
    // activations are shared by all channels
    assign a_addr = act_offset + addr_t'({bt, 1'b0});

    assign weight_rd = '{en: issue, addr0: w_addr, addr1: w_addr + 16'd1};
    assign act_rd    = '{en: issue, addr0: a_addr, addr1: a_addr + 16'd1};

    // flags follow the read through the sram latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr[0]  <= issue;
            last_sr[0] <= issue && last_bt;
            for (int i = 1; i < RD_LAT; i++) begin
                vld_sr[i]  <= vld_sr[i-1];
                last_sr[i] <= last_sr[i-1];
            end
        end
    end

    assign beat_push = vld_sr[RD_LAT-1];
    assign beat = '{
        last: last_sr[RD_LAT-1],
        act1: act_rdata1,
        act0: act_rdata0,
        wgt1: weight_rdata1,
        wgt0: weight_rdata0
    };

    // queue headroom only covers reads issued below the threshold
    a_no_read_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        almost_full |-> !(weight_rd.en || act_rd.en)
    );

endmodule

`default_nettype wire

// ==== source/operand_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_layer_cfg.svh"

module operand_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fc_layer_pkg::operand_beat_t beat_in,
    input  logic                        push,
    output fc_layer_pkg::operand_beat_t beat_out,
    input  logic                        pop,
    output logic                        empty,
    output logic                        almost_full
);
    import fc_layer_pkg::*;

    localparam int DEPTH    = `FC_Q_DEPTH;
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int AF_LEVEL = `FC_Q_DEPTH - `FC_RD_LAT - 1;

    operand_beat_t    mem [DEPTH];
    operand_beat_t    head_q;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign rd_ptr_nxt = pop ? ptr_inc(rd_ptr) : rd_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr <= rd_ptr_nxt;
            count  <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // head_q mirrors mem[rd_ptr]
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= beat_in;
        end
        // bypass when the new head is written in this same cycle
        if (push && (wr_ptr == rd_ptr_nxt)) begin
            head_q <= beat_in;
        end else begin
            head_q <= mem[rd_ptr_nxt];
        end
    end

    assign beat_out    = head_q;
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(AF_LEVEL));

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(DEPTH))
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    );

endmodule

`default_nettype wire

// ==== source/mac_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_accumulator (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fc_layer_pkg::operand_beat_t beat_out,
    input  logic                        empty,
    output logic                        pop,
    output fc_layer_pkg::psum_t         psum,
    output logic                        psum_valid
);
    import fc_layer_pkg::*;

    localparam int LANES = 8;

    logic [8*LANES-1:0] w_vec;
    logic [8*LANES-1:0] a_vec;
    logic signed [15:0] prod [LANES];
    logic               p_vld;
    logic               p_last;
    psum_t              acc;
    psum_t              beat_sum;
    psum_t              acc_nxt;

    // p_last doubles as the bubble after a channel's final beat
    assign pop = !empty && !p_last;

    assign w_vec = {beat_out.wgt1, beat_out.wgt0};
    assign a_vec = {beat_out.act1, beat_out.act0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p_vld  <= 1'b0;
            p_last <= 1'b0;
        end else begin
            p_vld  <= pop;
            p_last <= pop && beat_out.last;
        end
    end

    // products registered
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < LANES; i++) begin
                prod[i] <= $signed(w_vec[8*i +: 8]) * $signed(a_vec[8*i +: 8]);
            end
        end
    end

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            beat_sum = beat_sum + prod[i];
        end
    end

    assign acc_nxt = acc + beat_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc        <= '0;
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= p_vld && p_last;
            if (p_vld) begin
                // restart from zero for the next channel
                acc <= p_last ? '0 : acc_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (p_vld && p_last) begin
            psum <= acc_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== source/quant_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_layer_cfg.svh"

module quant_writer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  fc_layer_pkg::addr_t      act_offset,
    input  fc_layer_pkg::word_t      scale,
    input  fc_layer_pkg::psum_t      psum,
    input  logic                     psum_valid,
    output fc_layer_pkg::result_wr_t result_wr,
    output logic                     finish
);
    import fc_layer_pkg::*;

    localparam int CH_W = $clog2(`FC_OUT_CHANNELS);

    logic               run;
    logic [CH_W-1:0]    ch_cnt;
    logic               wr_last;
    psum_t              relu;
    logic signed [63:0] scaled;
    logic [7:0]         q_byte;

    assign relu   = psum[31] ? '0 : psum;
    assign scaled = relu * $signed(scale);

    // anything at bit 23 or above saturates
    assign q_byte = (scaled[63:23] == '0) ? scaled[23:16] : 8'd127;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run    <= 1'b0;
            ch_cnt <= '0;
            finish <= 1'b0;
        end else if (start && !run) begin
            run    <= 1'b1;
            ch_cnt <= '0;
            finish <= 1'b0;
        end else begin
            if (psum_valid) begin
                ch_cnt <= ch_cnt + 1'b1;
            end
            if (result_wr.en && wr_last) begin
                run    <= 1'b0;
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_wr.en <= 1'b0;
            wr_last      <= 1'b0;
        end else begin
            result_wr.en <= psum_valid;
            wr_last      <= psum_valid && (ch_cnt == CH_W'(`FC_OUT_CHANNELS - 1));
        end
        // four channels share one output word
        if (psum_valid) begin
            result_wr.addr <= act_offset + addr_t'(`FC_CH_WORDS)
                            + addr_t'(ch_cnt[CH_W-1:2]);
            result_wr.mask <= 4'b0001 << ch_cnt[1:0];
            result_wr.data <= word_t'(q_byte) << {ch_cnt[1:0], 3'b000};
        end
    end

    a_mask_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_wr.en |-> $onehot(result_wr.mask)
    );

    // the whole pipeline has drained once finish is up
    a_no_write_after_finish: assert property (
        @(posedge clk) disable iff (!rst_n)
        finish |-> !result_wr.en
    );

endmodule

`default_nettype wire

// ==== source/fc_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_layer_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     finish,
    input  fc_layer_pkg::addr_t      weight_offset,
    input  fc_layer_pkg::addr_t      act_offset,
    input  fc_layer_pkg::word_t      scale,
    output fc_layer_pkg::sram_rd_t   weight_rd,
    input  fc_layer_pkg::word_t      weight_rdata0,
    input  fc_layer_pkg::word_t      weight_rdata1,
    output fc_layer_pkg::sram_rd_t   act_rd,
    input  fc_layer_pkg::word_t      act_rdata0,
    input  fc_layer_pkg::word_t      act_rdata1,
    output fc_layer_pkg::result_wr_t result_wr
);
    import fc_layer_pkg::*;

    operand_beat_t rd_beat;
    logic          rd_push;
    operand_beat_t q_beat;
    logic          q_pop;
    logic          q_empty;
    logic          q_almost_full;
    psum_t         psum;
    logic          psum_valid;

    fc_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .almost_full   (q_almost_full),
        .weight_rd     (weight_rd),
        .act_rd        (act_rd),
        .weight_rdata0 (weight_rdata0),
        .weight_rdata1 (weight_rdata1),
        .act_rdata0    (act_rdata0),
        .act_rdata1    (act_rdata1),
        .beat          (rd_beat),
        .beat_push     (rd_push)
    );

    operand_queue u_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat_in     (rd_beat),
        .push        (rd_push),
        .beat_out    (q_beat),
        .pop         (q_pop),
        .empty       (q_empty),
        .almost_full (q_almost_full)
    );

    mac_accumulator u_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_out   (q_beat),
        .empty      (q_empty),
        .pop        (q_pop),
        .psum       (psum),
        .psum_valid (psum_valid)
    );

    quant_writer u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .act_offset (act_offset),
        .scale      (scale),
        .psum       (psum),
        .psum_valid (psum_valid),
        .result_wr  (result_wr),
        .finish     (finish)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/fc_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fc_layer_cfg.svh"

module fc_layer_tb;
    import fc_layer_pkg::*;

    localparam int NCH     = `FC_OUT_CHANNELS;
    localparam int NWORDS  = `FC_CH_WORDS;
    localparam int NREADS  = `FC_OUT_CHANNELS * `FC_BEATS;
    localparam int TIMEOUT = 20000;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       finish;
    addr_t      weight_offset;
    addr_t      act_offset;
    word_t      scale;
    sram_rd_t   weight_rd;
    sram_rd_t   act_rd;
    word_t      weight_rdata0;
    word_t      weight_rdata1;
    word_t      act_rdata0;
    word_t      act_rdata1;
    result_wr_t result_wr;

    word_t       wmem [65536];
    word_t       amem [65536];
    logic [63:0] w_stage;
    logic [63:0] a_stage;
    logic [7:0]  exp_byte [NCH];
    int          wr_idx;
    int          rd_idx;
    int          err_cnt;
    int          n;
    int          lane;
    int          base;
    logic        started;
    logic        finish_q;

    tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clk (.clk(clk), .rst_n(rst_n));

    fc_layer_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .finish        (finish),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .scale         (scale),
        .weight_rd     (weight_rd),
        .weight_rdata0 (weight_rdata0),
        .weight_rdata1 (weight_rdata1),
        .act_rd        (act_rd),
        .act_rdata0    (act_rdata0),
        .act_rdata1    (act_rdata1),
        .result_wr     (result_wr)
    );

    task automatic fail_stop(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // two sram stages, so data shows up two cycles after the strobe
    always begin : sram_model
        sram_rd_t w_req;
        sram_rd_t a_req;
        @(posedge clk);
        w_req = weight_rd;
        a_req = act_rd;
        #1;
        {weight_rdata1, weight_rdata0} = w_stage;
        {act_rdata1, act_rdata0} = a_stage;
        w_stage = {wmem[w_req.addr1], wmem[w_req.addr0]};
        a_stage = {amem[a_req.addr1], amem[a_req.addr0]};
    end

    // fills one run's regions and derives the expected bytes
    task automatic fill_run(input addr_t w_off, input addr_t a_off, input word_t scl);
        int         a_b;
        int         w_b;
        int         mag;
        int         sum;
        int         n_zero;
        int         n_sat;
        longint     scaled;
        logic [7:0] rnd8;
        addr_t      wa;
        n_zero = 0;
        n_sat  = 0;
        for (int k = 0; k < NWORDS; k++) begin
            amem[addr_t'(a_off + k)] = $urandom;
        end
        for (int c = 0; c < NCH; c++) begin
            sum = 0;
            for (int k = 0; k < NWORDS; k++) begin
                wa = addr_t'(w_off + c * NWORDS + k);
                for (int b = 0; b < 4; b++) begin
                    a_b  = $signed(amem[addr_t'(a_off + k)][8*b +: 8]);
                    mag  = $urandom % 128;
                    rnd8 = $urandom;
                    // lane sign bias pushes channels towards saturation or zero
                    case (c % 4)
                        1: w_b = (a_b < 0) ? -mag : mag;
                        2: w_b = (a_b < 0) ? mag : -mag;
                        default: w_b = $signed(rnd8);
                    endcase
                    wmem[wa][8*b +: 8] = w_b[7:0];
                    sum += a_b * w_b;
                end
            end
            if (sum < 0) begin
                exp_byte[c] = 8'd0;
                n_zero++;
            end else begin
                scaled = longint'(sum) * longint'(scl);
                if ((scaled >>> 23) == 0) begin
                    exp_byte[c] = scaled[23:16];
                end else begin
                    exp_byte[c] = 8'd127;
                    n_sat++;
                end
            end
        end
        assert (n_zero > 0 && n_sat > 0)
            else fail_stop("stimulus has no negative or no saturating channel");
    endtask

    task automatic run_layer(input addr_t w_off, input addr_t a_off, input word_t scl);
        int cnt;
        fill_run(w_off, a_off, scl);
        @(posedge clk);
        #1;
        weight_offset = w_off;
        act_offset    = a_off;
        scale         = scl;
        wr_idx        = 0;
        rd_idx        = 0;
        started       = 1'b1;
        start         = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (!finish) else fail_stop("finish did not clear on start");
        cnt = 0;
        while (!finish && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        assert (finish) else fail_stop("timeout waiting for finish");
        assert (wr_idx == NCH)
            else fail_stop($sformatf("FAILED write count: got %h expected %h", wr_idx, NCH));
        assert (rd_idx == NREADS)
            else fail_stop($sformatf("FAILED read count: got %h expected %h", rd_idx, NREADS));
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (finish) else fail_stop("finish dropped while idle");
        end
    endtask

    // output monitor, mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (!started) begin
                assert (!weight_rd.en && !act_rd.en && !result_wr.en && !finish)
                    else fail_stop("output active before the first start");
            end
            assert (weight_rd.en == act_rd.en)
                else fail_stop("weight and activation reads not issued together");
            if (weight_rd.en) begin
                base = int'(weight_offset) + (rd_idx / `FC_BEATS) * NWORDS;
                assert (rd_idx < NREADS) else fail_stop("more reads than the layer needs");
                assert (int'(weight_rd.addr0) >= base && int'(weight_rd.addr1) <= base + 99)
                    else fail_stop($sformatf("FAILED weight_rd.addr0: got %h region %h",
                                             weight_rd.addr0, base));
                assert (int'(act_rd.addr0) >= int'(act_offset)
                        && int'(act_rd.addr1) <= int'(act_offset) + 99)
                    else fail_stop($sformatf("FAILED act_rd.addr0: got %h region %h",
                                             act_rd.addr0, act_offset));
                rd_idx++;
            end
            if (result_wr.en) begin
                assert (!finish) else fail_stop("result write while finish is high");
                assert (wr_idx < NCH) else fail_stop("more result writes than channels");
                lane = wr_idx % 4;
                assert (result_wr.addr == addr_t'(act_offset + NWORDS + wr_idx / 4))
                    else fail_stop($sformatf("FAILED result_wr.addr: got %h expected %h",
                                             result_wr.addr, act_offset + NWORDS + wr_idx / 4));
                assert (result_wr.mask == 4'(1 << lane))
                    else fail_stop($sformatf("FAILED result_wr.mask: got %h expected %h",
                                             result_wr.mask, 4'(1 << lane)));
                assert (result_wr.data[8*lane +: 8] == exp_byte[wr_idx])
                    else fail_stop($sformatf("FAILED result_wr.data ch %0d: got %h expected %h",
                                             wr_idx, result_wr.data[8*lane +: 8],
                                             exp_byte[wr_idx]));
                wr_idx++;
            end
            if (finish && !finish_q) begin
                assert (wr_idx == NCH) else fail_stop("finish rose before the last write");
            end
            finish_q = finish;
        end
    end

    initial begin
        void'($urandom(5209));
        start         = 1'b0;
        weight_offset = '0;
        act_offset    = '0;
        scale         = '0;
        weight_rdata0 = '0;
        weight_rdata1 = '0;
        act_rdata0    = '0;
        act_rdata1    = '0;
        w_stage       = '0;
        a_stage       = '0;
        started       = 1'b0;
        finish_q      = 1'b0;
        err_cnt       = 0;
        wr_idx        = 0;
        rd_idx        = 0;
        for (int i = 0; i < 65536; i++) begin
            wmem[i] = $urandom;
            amem[i] = $urandom;
        end
        n = 0;
        while (!rst_n && n < 100) begin
            @(negedge clk);
            n++;
        end
        assert (rst_n) else fail_stop("reset never released");
        repeat (10) @(negedge clk);
        run_layer(addr_t'(16'h1000 + $urandom % 256), addr_t'(16'h0100 + $urandom % 128),
                  word_t'(12 + $urandom % 8));
        run_layer(addr_t'(16'h6000 + $urandom % 256), addr_t'(16'hc000 + $urandom % 128),
                  word_t'(24 + $urandom % 8));
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "errors seen during the run");
        end
    end

endmodule

`default_nettype wire

// ==== fc_layer.f ====
+incdir+source
source/fc_layer_pkg.sv
source/fc_sequencer.sv
source/operand_queue.sv
source/mac_accumulator.sv
source/quant_writer.sv
source/fc_layer_top.sv
test/tb_clock_gen.sv
test/fc_layer_tb.sv
